// ==== filelist.f ====
decodePkg.sv
controlUnit.sv
aluControl.sv
regFileBypass.sv
decode.sv
decode_checker.sv
decode_tb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module decode_tb -f filelist.f -o simv
./obj_dir/simv +verilator+error+limit+100 | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
grep -q "Finished with no errors" sim.log
echo "Simulation passed"

// ==== decode_tb.sv ====
// ****************************************
// Decode stage testbench
// Stimulus, shadow register file, reference
// model, compare process and watchdog
// ****************************************
`timescale 1ns/100ps

module decode_tb import decodePkg::*; ();

    localparam int numInstr = 351;

    logic        clk, rst, instrValid, instrReady, wbEn, outValid, outReady;
    logic [15:0] instr, wbData, rsData, rtData, imm;
    logic [2:0]  wbReg, dstReg;
    logic [1:0]  aluOp, branch;
    logic        invA, invB, cin, useImm, regWrite, memRead, memWrite, jump, halt, err;
    logic [64:0] outWord;

    logic [15:0] shadow [8];
    logic [64:0] expQ [$];
    logic [64:0] maskQ [$];
    logic [4:0]  legalOps [13] = '{OP_HALT, OP_NOP, OP_J, OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
                                    OP_BEQZ, OP_BNEZ, OP_ST, OP_LD, OP_LBI, OP_RALU};
    string       curTest;
    int          checkCount = 0;
    int          errCount = 0;
    int          errMark = 0;
    bit          randomReady = 0;
    bit          lastAccept = 0;

    decode i_decode (.*);

    assign outWord = {rsData, rtData, imm, dstReg, aluOp, invA, invB, cin, useImm, regWrite,
                      memRead, memWrite, branch, jump, halt, err};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Execute stage back-pressure
    initial begin
        outReady = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            outReady = randomReady ? 1'($urandom) : 1'b1;
        end
    end

    initial begin
        repeat (numInstr * 20) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("Finished with errors");
        $finish;
    end

    task automatic checkValue(input string name, input logic [64:0] expV, input logic [64:0] actV);
        checkCount++;
        if (expV !== actV) begin
            errCount++;
            $display("error %s: expected %h, actual %h", name, expV, actV);
        end
    endtask

    // Expected fields from the ISA rules, with a mask of the fields that matter
    function automatic void refDecode(input logic [15:0] w, output logic [64:0] val,
                                      output logic [64:0] mask);
        logic [4:0]  op;
        logic [1:0]  fn;
        logic [15:0] immE;
        logic [2:0]  dstE;
        logic [1:0]  aluE, brE;
        logic        invAE, invBE, cinE, useImmE, regWrE, memRdE, memWrE, jumpE, haltE, errE;
        logic        mImm, mDst, mAlu, aluFn;
        op = w[15:11];
        fn = w[1:0];
        {immE, dstE, aluE, brE} = '0;
        {invAE, invBE, cinE, useImmE, regWrE, memRdE, memWrE, jumpE, haltE, errE} = '0;
        {mImm, mDst, mAlu, aluFn} = '0;
        case (op)
            OP_HALT: haltE = 1'b1;
            OP_NOP: begin
            end
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                {useImmE, regWrE, mImm, mDst, mAlu, aluFn} = '1;
                dstE = w[7:5];
                fn = (op == OP_ADDI) ? FN_ADD : (op == OP_SUBI) ? FN_SUB :
                     (op == OP_XORI) ? FN_XOR : FN_ANDN;
                // Logical forms take an unsigned immediate
                immE = (op == OP_XORI || op == OP_ANDNI) ? {11'd0, w[4:0]} : {{11{w[4]}}, w[4:0]};
            end
            OP_LD, OP_ST: begin
                {useImmE, mImm, mAlu} = '1;
                aluE = ALU_ADD;
                immE = {{11{w[4]}}, w[4:0]};
                memRdE = (op == OP_LD);
                memWrE = (op == OP_ST);
                regWrE = (op == OP_LD);
                mDst = (op == OP_LD);
                dstE = w[7:5];
            end
            OP_LBI: begin
                {regWrE, mDst, mImm} = '1;
                dstE = w[10:8];
                immE = {{8{w[7]}}, w[7:0]};
            end
            OP_RALU: begin
                {regWrE, mDst, mAlu, aluFn} = '1;
                dstE = w[4:2];
            end
            OP_BEQZ, OP_BNEZ: begin
                mImm = 1'b1;
                brE = (op == OP_BEQZ) ? BR_EQZ : BR_NEZ;
                immE = {{8{w[7]}}, w[7:0]};
            end
            OP_J: begin
                {jumpE, mImm} = '1;
                immE = {{5{w[10]}}, w[10:0]};
            end
            default: errE = 1'b1;
        endcase
        if (aluFn) begin
            case (fn)
                FN_ADD: aluE = ALU_ADD;
                FN_SUB: {aluE, invAE, cinE} = {ALU_ADD, 2'b11};
                FN_XOR: aluE = ALU_XOR;
                default: {aluE, invBE} = {ALU_ANDN, 1'b1};
            endcase
        end
        val = {shadow[w[10:8]], shadow[w[7:5]], immE, dstE, aluE, invAE, invBE, cinE, useImmE,
               regWrE, memRdE, memWrE, brE, jumpE, haltE, errE};
        mask = {32'hffff_ffff, {16{mImm}}, {3{mDst}}, {6{mAlu}}, 8'hff};
    endfunction

    function automatic logic [15:0] rWord(input logic [4:0] op, input logic [2:0] rs,
                                          input logic [2:0] rt, input logic [2:0] rd,
                                          input logic [1:0] fn);
        instrWord_u u;
        u.rForm.opcode = op;
        u.rForm.rs = rs;
        u.rForm.rt = rt;
        u.rForm.rd = rd;
        u.rForm.func = fn;
        return u;
    endfunction

    function automatic logic [15:0] iWord(input logic [4:0] op, input logic [2:0] rs,
                                          input logic [2:0] rdI, input logic [4:0] imm5);
        instrWord_u u;
        u.iForm.opcode = op;
        u.iForm.rs = rs;
        u.iForm.rdI = rdI;
        u.iForm.imm5 = imm5;
        return u;
    endfunction

    function automatic bit isLegal(input logic [4:0] op);
        foreach (legalOps[i]) if (legalOps[i] == op) return 1'b1;
        return 1'b0;
    endfunction

    // Holds one instruction until accepted, with an optional writeback in its first cycle
    task automatic issue(input logic [15:0] word, input logic doWb, input logic [2:0] r,
                         input logic [15:0] d);
        logic acc;
        instrValid = 1'b1;
        instr = word;
        wbEn = doWb;
        wbReg = r;
        wbData = d;
        do begin
            @(negedge clk);
            acc = instrReady;
            @(posedge clk);
            #1;
            wbEn = 1'b0;
        end while (!acc);
        instrValid = 1'b0;
    endtask

    task automatic send(input logic [15:0] word);
        issue(word, 1'b0, 3'd0, 16'd0);
    endtask

    task automatic writeReg(input logic [2:0] r, input logic [15:0] d);
        wbEn = 1'b1;
        wbReg = r;
        wbData = d;
        @(posedge clk);
        #1;
        wbEn = 1'b0;
    endtask

    task automatic finishTest();
        while (expQ.size() != 0) begin
            @(posedge clk);
            #1;
        end
        $display("test %s finished with %0d errors", curTest, errCount - errMark);
        errMark = errCount;
    endtask

    // Monitor and compare on the falling edge, where all signals are settled
    initial begin
        logic [64:0] expV;
        logic [64:0] maskV;
        forever begin
            @(negedge clk);
            if (rst) begin
                foreach (shadow[i]) shadow[i] = '0;
                lastAccept = 1'b0;
            end else begin
                if (lastAccept && !outValid) begin
                    errCount++;
                    $display("%s: no output one cycle after an accepted instruction", curTest);
                end
                if (wbEn) shadow[wbReg] = wbData;
                if (outValid && outReady) begin
                    if (expQ.size() == 0) begin
                        errCount++;
                        $display("%s: output transfer with nothing expected", curTest);
                    end else begin
                        expV = expQ.pop_front();
                        maskV = maskQ.pop_front();
                        checkValue(curTest, expV & maskV, outWord & maskV);
                    end
                end
                lastAccept = instrValid && instrReady;
                if (lastAccept) begin
                    refDecode(instr, expV, maskV);
                    expQ.push_back(expV);
                    maskQ.push_back(maskV);
                end
            end
        end
    end

    initial begin
        int seedInit;
        seedInit = $urandom(32'he4fe_5fff);
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        wbEn = 1'b0;
        wbReg = '0;
        wbData = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        curTest = "reset";
        @(negedge clk);
        checkValue(curTest, 65'(2'b01), 65'({outValid, instrReady}));
        @(posedge clk);
        #1;
        // Registers 6, 7 and 0 stay unwritten
        for (int r = 1; r < 6; r++) writeReg(3'(r), 16'($urandom) | 16'h0001);
        for (int r = 1; r < 8; r += 2) send(rWord(OP_RALU, 3'(r), 3'(r + 1), 3'(r), FN_ADD));
        finishTest();

        curTest = "bypass";
        for (int r = 0; r < 8; r++) begin
            if (r % 2 == 0)
                issue(rWord(OP_RALU, 3'(r), 3'(r + 3), 3'(r), FN_XOR), 1'b1, 3'(r), 16'($urandom));
            else
                issue(rWord(OP_RALU, 3'(r + 5), 3'(r), 3'(r), FN_SUB), 1'b1, 3'(r), 16'($urandom));
        end
        finishTest();

        curTest = "alu";
        for (int k = 3; k < 7; k++)
            send(iWord(legalOps[k], 3'($urandom), 3'($urandom), 5'($urandom)));
        for (int k = 0; k < 4; k++)
            send(rWord(OP_RALU, 3'($urandom), 3'($urandom), 3'($urandom), 2'(k)));
        finishTest();

        curTest = "immediate";
        send({OP_LBI, 3'd3, 8'h85});
        send({OP_LBI, 3'd5, 8'h7f});
        send(iWord(OP_XORI, 3'd1, 3'd2, 5'h15));
        send(iWord(OP_ANDNI, 3'd4, 3'd6, 5'h1f));
        send({OP_BEQZ, 3'd2, 8'h80});
        send({OP_BNEZ, 3'd6, 8'h10});
        send({OP_J, 11'h400});
        send({OP_J, 11'h3ff});
        send(iWord(OP_LD, 3'd7, 3'd1, 5'h10));
        send(iWord(OP_ST, 3'd0, 3'd3, 5'h0f));
        send({OP_HALT, 11'd0});
        send({OP_NOP, 11'd0});
        finishTest();

        curTest = "backpressure";
        randomReady = 1'b1;
        for (int n = 0; n < 300; n++) begin
            if ($urandom % 4 == 0) begin
                @(posedge clk);
                #1;
            end
            issue({legalOps[$urandom % 13], 11'($urandom)}, 1'($urandom), 3'($urandom),
                  16'($urandom));
        end
        finishTest();
        randomReady = 1'b0;

        curTest = "illegal";
        for (int k = 0; k < 32; k++) begin
            if (!isLegal(5'(k))) send({5'(k), 11'($urandom)});
        end
        finishTest();

        errCount += i_decode.assertChk.failCount;
        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== decode_checker.sv ====
// ****************************************
// Handshake and reset assertions for the
// decode stage, bound into decode
// ****************************************
`timescale 1ns/100ps

module decodeChecker (
    input logic        clk,
    input logic        rst,
    input logic        instrValid,
    input logic        outValid,
    input logic        outReady,
    input logic [15:0] rsData,
    input logic [15:0] rtData,
    input logic [15:0] imm,
    input logic [2:0]  dstReg,
    input logic [1:0]  aluOp,
    input logic        invA,
    input logic        invB,
    input logic        cin,
    input logic        useImm,
    input logic        regWrite,
    input logic        memRead,
    input logic        memWrite,
    input logic [1:0]  branch,
    input logic        jump,
    input logic        halt,
    input logic        err
);

    int failCount = 0;

    // Output slot is empty after reset
    resetEmpty: assert property (@(posedge clk) rst |=> !outValid)
        else begin
            failCount++;
            $error("outValid high in the cycle after reset");
        end

    // Stalled result holds until the execute stage takes it
    stallHold: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable({rsData, rtData, imm, dstReg, aluOp,
                                                       invA, invB, cin, useImm, regWrite,
                                                       memRead, memWrite, branch, jump, halt,
                                                       err}))
        else begin
            failCount++;
            $error("output changed while stalled");
        end

    // Free or draining slot takes a presented instruction
    readyRule: assert property (@(posedge clk) disable iff (rst)
        instrValid && (!outValid || outReady) |=> outValid)
        else begin
            failCount++;
            $error("instruction not taken while the output slot was empty or draining");
        end

    // Drained slot with nothing presented goes empty
    drainEmpty: assert property (@(posedge clk) disable iff (rst)
        outValid && outReady && !instrValid |=> !outValid)
        else begin
            failCount++;
            $error("outValid still high after a drain with no new instruction");
        end

endmodule

bind decode decodeChecker assertChk (.*);

// ==== decode.sv ====
// ****************************************
// Decode stage top level
// Register read, immediate extension and
// the output pipeline register
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module decode import decodePkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    output logic        instrReady,
    input  logic [15:0] instr,
    input  logic        wbEn,
    input  logic [2:0]  wbReg,
    input  logic [15:0] wbData,
    output logic        outValid,
    input  logic        outReady,
    output logic [15:0] rsData,
    output logic [15:0] rtData,
    output logic [15:0] imm,
    output logic [2:0]  dstReg,
    output logic [1:0]  aluOp,
    output logic        invA,
    output logic        invB,
    output logic        cin,
    output logic        useImm,
    output logic        regWrite,
    output logic        memRead,
    output logic        memWrite,
    output logic [1:0]  branch,
    output logic        jump,
    output logic        halt,
    output logic        err
);

    instrWord_u  iw;
    logic [1:0]  aluClass;
    logic [1:0]  immSel;
    logic [1:0]  dstKind;
    logic [15:0] rsNext, rtNext, immNext;
    logic [2:0]  dstNext;
    logic [1:0]  aluOpNext, branchNext;
    logic        invANext, invBNext, cinNext, useImmNext, regWriteNext;
    logic        memReadNext, memWriteNext, jumpNext, haltNext, errNext;
    logic        accept;

    assign iw = instr;

    controlUnit ctrl (.instr(iw), .aluClass(aluClass), .immSel(immSel), .useImm(useImmNext),
                      .regWrite(regWriteNext), .dstKind(dstKind), .memRead(memReadNext),
                      .memWrite(memWriteNext), .branch(branchNext), .jump(jumpNext),
                      .halt(haltNext), .err(errNext));

    aluControl aluCtrl (.aluClass(aluClass), .opLow(iw.rForm.opcode[1:0]),
                        .func(iw.rForm.func), .aluOp(aluOpNext), .invA(invANext),
                        .invB(invBNext), .cin(cinNext));

    regFileBypass regFile (.clk(clk), .rst(rst), .rdSel1(iw.rForm.rs), .rdSel2(iw.rForm.rt),
                           .wrSel(wbReg), .wrData(wbData), .wrEn(wbEn),
                           .rdData1(rsNext), .rdData2(rtNext));

    // Destination field differs per format
    always_comb begin
        case (dstKind)
            DST_IFORM: dstNext = iw.iForm.rdI;
            DST_RS:    dstNext = iw.rForm.rs;
            default:   dstNext = iw.rForm.rd;
        endcase
    end

    always_comb begin
        case (immSel)
            IMM_Z5:  immNext = {11'd0, iw.iForm.imm5};
            IMM_S8:  immNext = {{8{instr[7]}}, instr[7:0]};
            IMM_S11: immNext = {{5{instr[10]}}, instr[10:0]};
            default: immNext = {{11{iw.iForm.imm5[4]}}, iw.iForm.imm5};
        endcase
    end

    // Single output slot, refilled in the cycle it drains
    assign instrReady = !outValid || outReady;
    assign accept     = instrValid && instrReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (instrReady) begin
            outValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsData   <= rsNext;
            rtData   <= rtNext;
            imm      <= immNext;
            dstReg   <= dstNext;
            aluOp    <= aluOpNext;
            invA     <= invANext;
            invB     <= invBNext;
            cin      <= cinNext;
            useImm   <= useImmNext;
            regWrite <= regWriteNext;
            memRead  <= memReadNext;
            memWrite <= memWriteNext;
            branch   <= branchNext;
            jump     <= jumpNext;
            halt     <= haltNext;
            err      <= errNext;
        end
    end

endmodule

`default_nettype wire

// ==== regFileBypass.sv ====
// ****************************************
// Register file, 8 x 16 bits
// Two read ports, one write port and a
// write-to-read bypass
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module regFileBypass (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  rdSel1,
    input  logic [2:0]  rdSel2,
    input  logic [2:0]  wrSel,
    input  logic [15:0] wrData,
    input  logic        wrEn,
    output logic [15:0] rdData1,
    output logic [15:0] rdData2
);

    logic [15:0] regs [8];
    logic        hit1;
    logic        hit2;

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            regs[wrSel] <= wrData;
        end
    end

    // Same-cycle write wins over the stored value
    assign hit1 = wrEn && (wrSel == rdSel1);
    assign hit2 = wrEn && (wrSel == rdSel2);

    assign rdData1 = hit1 ? wrData : regs[rdSel1];
    assign rdData2 = hit2 ? wrData : regs[rdSel2];

endmodule

`default_nettype wire

// ==== aluControl.sv ====
// ****************************************
// ALU control decoder
// Operation select and operand invert and
// carry controls
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module aluControl import decodePkg::*; (
    input  logic [1:0] aluClass,
    input  logic [1:0] opLow,
    input  logic [1:0] func,
    output logic [1:0] aluOp,
    output logic       invA,
    output logic       invB,
    output logic       cin
);

    logic [1:0] fnCode;

    // Immediate forms carry the function in the opcode low bits
    assign fnCode = (aluClass == CLS_REG) ? func : opLow;

    always_comb begin
        aluOp = ALU_PASSB;
        invA  = 1'b0;
        invB  = 1'b0;
        cin   = 1'b0;
        case (aluClass)
            CLS_NONE: aluOp = ALU_PASSB;
            CLS_ADDR: aluOp = ALU_ADD;
            default: begin
                case (fnCode)
                    FN_ADD: aluOp = ALU_ADD;
                    // B - A as ~A + B + 1
                    FN_SUB: begin
                        aluOp = ALU_ADD;
                        invA  = 1'b1;
                        cin   = 1'b1;
                    end
                    FN_XOR: aluOp = ALU_XOR;
                    default: begin
                        aluOp = ALU_ANDN;
                        invB  = 1'b1;
                    end
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
// ****************************************
// Main opcode decoder
// Register, memory, immediate, branch and
// error controls
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module controlUnit import decodePkg::*; (
    input  instrWord_u instr,
    output logic [1:0] aluClass,
    output logic [1:0] immSel,
    output logic       useImm,
    output logic       regWrite,
    output logic [1:0] dstKind,
    output logic       memRead,
    output logic       memWrite,
    output logic [1:0] branch,
    output logic       jump,
    output logic       halt,
    output logic       err
);

    always_comb begin
        // Defaults describe a NOP
        aluClass = CLS_NONE;
        immSel   = IMM_S5;
        useImm   = 1'b0;
        regWrite = 1'b0;
        dstKind  = DST_RFORM;
        memRead  = 1'b0;
        memWrite = 1'b0;
        branch   = BR_NONE;
        jump     = 1'b0;
        halt     = 1'b0;
        err      = 1'b0;

        case (instr.rForm.opcode)
            OP_HALT: begin
                halt = 1'b1;
            end
            OP_NOP: begin
            end
            OP_ADDI, OP_SUBI: begin
                aluClass = CLS_IMM;
                useImm   = 1'b1;
                regWrite = 1'b1;
                dstKind  = DST_IFORM;
            end
            // Logical immediates are zero extended
            OP_XORI, OP_ANDNI: begin
                aluClass = CLS_IMM;
                immSel   = IMM_Z5;
                useImm   = 1'b1;
                regWrite = 1'b1;
                dstKind  = DST_IFORM;
            end
            OP_ST: begin
                aluClass = CLS_ADDR;
                useImm   = 1'b1;
                memWrite = 1'b1;
                dstKind  = DST_IFORM;
            end
            OP_LD: begin
                aluClass = CLS_ADDR;
                useImm   = 1'b1;
                memRead  = 1'b1;
                regWrite = 1'b1;
                dstKind  = DST_IFORM;
            end
            // LBI writes the sign-extended byte into rs
            OP_LBI: begin
                immSel   = IMM_S8;
                useImm   = 1'b1;
                regWrite = 1'b1;
                dstKind  = DST_RS;
            end
            OP_RALU: begin
                aluClass = CLS_REG;
                regWrite = 1'b1;
            end
            OP_BEQZ: begin
                immSel = IMM_S8;
                branch = BR_EQZ;
            end
            OP_BNEZ: begin
                immSel = IMM_S8;
                branch = BR_NEZ;
            end
            OP_J: begin
                immSel = IMM_S11;
                jump   = 1'b1;
            end
            default: begin
                err = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== decodePkg.sv ====
// ****************************************
// Shared decode stage definitions
// Opcodes, function codes, ALU codes,
// immediate and branch selects, and the
// instruction word union
// ****************************************
package decodePkg;

    // Opcodes in bits 15 to 11
    localparam logic [4:0] OP_HALT  = 5'b00000;
    localparam logic [4:0] OP_NOP   = 5'b00001;
    localparam logic [4:0] OP_J     = 5'b00100;
    localparam logic [4:0] OP_ADDI  = 5'b01000;
    localparam logic [4:0] OP_SUBI  = 5'b01001;
    localparam logic [4:0] OP_XORI  = 5'b01010;
    localparam logic [4:0] OP_ANDNI = 5'b01011;
    localparam logic [4:0] OP_BEQZ  = 5'b01100;
    localparam logic [4:0] OP_BNEZ  = 5'b01101;
    localparam logic [4:0] OP_ST    = 5'b10000;
    localparam logic [4:0] OP_LD    = 5'b10001;
    localparam logic [4:0] OP_LBI   = 5'b11000;
    localparam logic [4:0] OP_RALU  = 5'b11011;

    // Function field of the register ALU group, same order as the
    // low two opcode bits of the immediate ALU forms
    localparam logic [1:0] FN_ADD  = 2'b00;
    localparam logic [1:0] FN_SUB  = 2'b01;
    localparam logic [1:0] FN_XOR  = 2'b10;
    localparam logic [1:0] FN_ANDN = 2'b11;

    // ALU operations
    localparam logic [1:0] ALU_ADD   = 2'b00;
    localparam logic [1:0] ALU_XOR   = 2'b01;
    localparam logic [1:0] ALU_ANDN  = 2'b10;
    localparam logic [1:0] ALU_PASSB = 2'b11;

    // Where the ALU operation comes from
    localparam logic [1:0] CLS_NONE = 2'b00;
    localparam logic [1:0] CLS_IMM  = 2'b01;
    localparam logic [1:0] CLS_REG  = 2'b10;
    localparam logic [1:0] CLS_ADDR = 2'b11;

    // Immediate extension
    localparam logic [1:0] IMM_S5  = 2'b00;
    localparam logic [1:0] IMM_Z5  = 2'b01;
    localparam logic [1:0] IMM_S8  = 2'b10;
    localparam logic [1:0] IMM_S11 = 2'b11;

    // Branch conditions
    localparam logic [1:0] BR_NONE = 2'b00;
    localparam logic [1:0] BR_EQZ  = 2'b01;
    localparam logic [1:0] BR_NEZ  = 2'b10;

    // Destination register field
    localparam logic [1:0] DST_RFORM = 2'b00;
    localparam logic [1:0] DST_IFORM = 2'b01;
    localparam logic [1:0] DST_RS    = 2'b10;

    // One instruction word, register view and immediate view
    typedef union packed {
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [2:0] rt;
            logic [2:0] rd;
            logic [1:0] func;
        } rForm;
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [2:0] rdI;
            logic [4:0] imm5;
        } iForm;
    } instrWord_u;

endpackage
